// ==== project.f ====
+incdir+source
source/frame_pkg.sv
source/link_pkg.sv
source/frame_buffer.sv
source/frame_assembler.sv
source/backoff_timer.sv
source/xmit_controller.sv
source/xmit_top.sv
testbench/tb_xmit_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the transmitter testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_xmit_top -f project.f -o sim_xmit

out=$(./obj_dir/sim_xmit)
echo "$out"

# pass only when the testbench printed the pass line
echo "$out" | grep -qx "TEST PASSED"

// ==== source/backoff_timer.sv ====
`include "xmit_config.svh"

module backoff_timer (
    input  logic clk,
    input  logic rst,
    input  logic cardet,
    input  logic access_req,
    output logic access_grant
);
    import link_pkg::*;

    localparam int QW = $clog2(`DIFS_CYCLES + 1);
    localparam int CW = $clog2(`SLOT_CYCLES);
    localparam int SW = $clog2(`MAX_SLOTS + 1);
    localparam int RW = $clog2(`MAX_SLOTS);

    access_state_t state, next;
    logic [QW-1:0] quiet_cnt;
    logic [CW-1:0] slot_cyc;
    logic [SW-1:0] slots_left;
    logic [15:0]   lfsr;
    logic          quiet_ok;
    logic          slot_end;

    // quiet for a full DIFS and still quiet now
    assign quiet_ok = (quiet_cnt == QW'(`DIFS_CYCLES)) && !cardet;
    assign slot_end = slot_cyc == CW'(`SLOT_CYCLES - 1);
    assign access_grant = (state == CLEAR) && !cardet;

    always_comb begin
        next = state;
        case (state)
            IDLE:    if (access_req) next = DEFER;
            DEFER:   if (quiet_ok) next = BACKOFF;
            BACKOFF: begin
                if (cardet) next = DEFER;
                else if (slot_end && slots_left == SW'(1)) next = CLEAR;
            end
            CLEAR:   next = cardet ? DEFER : IDLE;
            default: next = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= IDLE;
            quiet_cnt  <= '0;
            slot_cyc   <= '0;
            slots_left <= '0;
            lfsr       <= 16'hACE1;
        end else begin
            state <= next;
            // galois lfsr, taps 16 14 13 11
            lfsr <= {1'b0, lfsr[15:1]} ^ (lfsr[0] ? 16'hB400 : 16'h0000);
            // saturating count of consecutive idle cycles
            if (cardet) quiet_cnt <= '0;
            else if (quiet_cnt != QW'(`DIFS_CYCLES)) quiet_cnt <= quiet_cnt + 1'b1;
            if (state == DEFER && next == BACKOFF) begin
                slots_left <= SW'(lfsr[RW-1:0]) + 1'b1;
                slot_cyc   <= '0;
            end else if (state == BACKOFF) begin
                slot_cyc <= slot_end ? '0 : slot_cyc + 1'b1;
                if (slot_end) slots_left <= slots_left - 1'b1;
            end
        end
    end

    // grant is a single pulse on a quiet channel while the controller asks
    grant_pulse: assert property (
        @(posedge clk) disable iff (rst)
        access_grant |-> access_req && !cardet ##1 !access_grant
    ) else $error("access grant outside a quiet request");

endmodule

// ==== source/frame_assembler.sv ====
module frame_assembler (
    input  logic                  clk,
    input  logic                  rst,
    input  frame_pkg::field_sel_t field_sel,
    input  frame_pkg::byte_t      host_byte,
    input  frame_pkg::byte_t      mac,
    input  logic                  strobe,
    input  logic                  crc_clear,
    output frame_pkg::byte_t      wr_byte
);
    import frame_pkg::*;

    byte_t crc;

    always_comb begin
        case (field_sel)
            FIELD_PREAMBLE: wr_byte = PREAMBLE_BYTE;
            FIELD_SFD:      wr_byte = SFD_BYTE;
            FIELD_HOST:     wr_byte = host_byte;
            FIELD_SRC:      wr_byte = mac;
            FIELD_FCS:      wr_byte = crc;
            default:        wr_byte = '0;
        endcase
    end

    // running fcs over dest, src, type and payload
    // strobe only comes with those fields
    always_ff @(posedge clk) begin
        if (rst || crc_clear) begin
            crc <= '0;
        end else if (strobe) begin
            crc <= crc8(crc, wr_byte);
        end
    end

endmodule

// ==== source/frame_buffer.sv ====
`include "xmit_config.svh"

module frame_buffer (
    input  logic                 clk,
    input  logic                 rst,
    input  frame_pkg::buf_wr_t   wr,
    input  logic                 rd_en,
    input  frame_pkg::buf_addr_t rd_addr,
    output frame_pkg::byte_t     rd_data
);
    import frame_pkg::*;

    byte_t mem [`BUF_DEPTH];

    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[wr.addr] <= wr.data;
        end
    end

    // read data holds until the next read
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

    // loading and sending never overlap
    no_read_during_write: assert property (
        @(posedge clk) disable iff (rst)
        !(wr.en && rd_en)
    ) else $error("frame buffer read and written in the same cycle");

endmodule

// ==== source/frame_pkg.sv ====
`include "xmit_config.svh"

package frame_pkg;

    typedef logic [7:0] byte_t;
    typedef logic [$clog2(`BUF_DEPTH)-1:0] buf_addr_t;
    typedef logic [7:0] ftype_t;

    // frame types, raw has no FCS, ackreq also waits for an ACK
    localparam ftype_t FTYPE_RAW    = 8'h30;
    localparam ftype_t FTYPE_DATA   = 8'h31;
    localparam ftype_t FTYPE_ACKREQ = 8'h32;

    localparam byte_t PREAMBLE_BYTE = 8'h55;
    localparam byte_t SFD_BYTE      = 8'hD0;

    // source of the byte written into the frame buffer
    typedef logic [2:0] field_sel_t;
    localparam field_sel_t FIELD_PREAMBLE = 3'd0;
    localparam field_sel_t FIELD_SFD      = 3'd1;
    localparam field_sel_t FIELD_HOST     = 3'd2;
    localparam field_sel_t FIELD_SRC      = 3'd3;
    localparam field_sel_t FIELD_FCS      = 3'd4;

    typedef struct packed {
        logic      en;
        buf_addr_t addr;
        byte_t     data;
    } buf_wr_t;

    // crc-8, poly x^8+x^2+x+1, msb first, no reflection
    function automatic byte_t crc8(input byte_t crc, input byte_t data);
        byte_t c;
        c = crc ^ data;
        for (int i = 0; i < 8; i++) begin
            c = c[7] ? ((c << 1) ^ 8'h07) : (c << 1);
        end
        return c;
    endfunction

endpackage

// ==== source/link_pkg.sv ====
package link_pkg;

    // channel access FSM
    typedef enum logic [1:0] {
        IDLE,
        DEFER,
        BACKOFF,
        CLEAR
    } access_state_t;

    // transmitter status seen by the host
    typedef struct packed {
        logic       busy;
        logic [2:0] attempt;
        logic [7:0] err_count;
    } xmit_status_t;

endpackage

// ==== source/xmit_config.svh ====
`ifndef XMIT_CONFIG_SVH
`define XMIT_CONFIG_SVH

// frame layout
`define PREAMBLE_LENGTH 2
`define MAX_PAYLOAD     255
`define BUF_DEPTH       512

// channel access timing, in clock cycles
`define DIFS_CYCLES     80
`define SLOT_CYCLES     8
// random backoff draws 1 to MAX_SLOTS slots
`define MAX_SLOTS       16

// acknowledge and retry
`define ACK_TIMEOUT     256
`define MAX_ATTEMPTS    5

`endif

// ==== source/xmit_controller.sv ====
`include "xmit_config.svh"

module xmit_controller (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   xvalid,
    input  logic                   xsend,
    input  frame_pkg::byte_t       xdata,
    output logic                   xrdy,
    output frame_pkg::field_sel_t  field_sel,
    output logic                   strobe,
    output logic                   crc_clear,
    output frame_pkg::buf_wr_t     wr,
    output logic                   rd_en,
    output frame_pkg::buf_addr_t   rd_addr,
    input  frame_pkg::byte_t       rd_data,
    output logic                   access_req,
    input  logic                   access_grant,
    output logic                   tx_valid,
    input  logic                   tx_ready,
    output frame_pkg::byte_t       tx_data,
    output logic                   tx_last,
    input  logic                   ack_received,
    output link_pkg::xmit_status_t status
);
    import frame_pkg::*;

    localparam int PW = $clog2(`PREAMBLE_LENGTH + 1);
    localparam int AW = $clog2(`ACK_TIMEOUT);

    typedef enum logic [3:0] {
        IDLE, LOAD_PREAMBLE, LOAD_SFD, LOAD_DEST, LOAD_SRC, LOAD_FTYPE,
        LOAD_PAYLOAD, LOAD_FCS, REQUEST, TRANSMIT, ACK_WAIT
    } ctl_state_t;

    ctl_state_t    state, next;
    logic [PW-1:0] pre_cnt;
    byte_t         pay_cnt;
    logic [AW-1:0] ack_cnt;
    logic [2:0]    attempt;
    logic [7:0]    err_count;
    byte_t         dest_q;
    ftype_t        ftype_q;
    buf_addr_t     wr_ptr;
    // address of the last stored byte, i.e. frame length - 1
    buf_addr_t     frame_end;
    buf_addr_t     rd_ptr;
    logic          rd_done;
    logic          rd_pending;
    logic          rd_last;
    logic          accept;
    logic          pay_end;
    logic          out_load;
    logic          tx_done;
    logic          ack_timeout;

    assign xrdy        = state inside {IDLE, LOAD_FTYPE, LOAD_PAYLOAD};
    assign accept      = xvalid && xrdy;
    // xsend or the payload limit closes the frame
    assign pay_end     = (state == LOAD_PAYLOAD) && accept
                         && (xsend || pay_cnt == 8'(`MAX_PAYLOAD - 1));
    assign out_load    = rd_pending && (!tx_valid || tx_ready);
    assign tx_done     = (state == TRANSMIT) && tx_valid && tx_ready && tx_last;
    assign ack_timeout = ack_cnt == AW'(`ACK_TIMEOUT - 1);
    assign access_req  = state == REQUEST;
    assign crc_clear   = state == IDLE;
    assign rd_addr     = rd_ptr;
    // read ahead whenever the one-entry stage is free or being drained
    assign rd_en = (state == REQUEST && access_grant)
                   || (state == TRANSMIT && !rd_done && (!rd_pending || out_load));
    assign status = '{busy: state != IDLE, attempt: attempt, err_count: err_count};

    // buffer write side, data field doubles as the host byte
    always_comb begin
        field_sel = FIELD_HOST;
        wr.en     = 1'b0;
        wr.addr   = wr_ptr;
        wr.data   = xdata;
        strobe    = 1'b0;
        case (state)
            LOAD_PREAMBLE: begin
                field_sel = FIELD_PREAMBLE;
                wr.en     = 1'b1;
            end
            LOAD_SFD: begin
                field_sel = FIELD_SFD;
                wr.en     = 1'b1;
            end
            LOAD_DEST: begin
                wr.en   = 1'b1;
                wr.data = dest_q;
                strobe  = 1'b1;
            end
            LOAD_SRC: begin
                field_sel = FIELD_SRC;
                wr.en     = 1'b1;
                strobe    = 1'b1;
            end
            LOAD_FTYPE, LOAD_PAYLOAD: begin
                wr.en  = accept;
                strobe = accept;
            end
            LOAD_FCS: begin
                field_sel = FIELD_FCS;
                wr.en     = 1'b1;
            end
            default: ;
        endcase
    end

    always_comb begin
        next = state;
        case (state)
            IDLE:          if (accept) next = LOAD_PREAMBLE;
            LOAD_PREAMBLE: if (pre_cnt == PW'(`PREAMBLE_LENGTH - 1)) next = LOAD_SFD;
            LOAD_SFD:      next = LOAD_DEST;
            LOAD_DEST:     next = LOAD_SRC;
            LOAD_SRC:      next = LOAD_FTYPE;
            LOAD_FTYPE:    if (accept) next = LOAD_PAYLOAD;
            LOAD_PAYLOAD:  if (pay_end) next = (ftype_q == FTYPE_RAW) ? REQUEST : LOAD_FCS;
            LOAD_FCS:      next = REQUEST;
            REQUEST:       if (access_grant) next = TRANSMIT;
            TRANSMIT:      if (tx_done) next = (ftype_q == FTYPE_ACKREQ) ? ACK_WAIT : IDLE;
            ACK_WAIT: begin
                if (ack_received) next = IDLE;
                else if (ack_timeout) next = (attempt == 3'(`MAX_ATTEMPTS)) ? IDLE : REQUEST;
            end
            default:       next = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= IDLE;
            pre_cnt   <= '0;
            pay_cnt   <= '0;
            ack_cnt   <= '0;
            attempt   <= '0;
            err_count <= '0;
            wr_ptr    <= '0;
        end else begin
            state <= next;
            if (state == IDLE) begin
                pre_cnt <= '0;
                pay_cnt <= '0;
                wr_ptr  <= '0;
            end
            if (state == LOAD_PREAMBLE) pre_cnt <= pre_cnt + 1'b1;
            if (state == LOAD_PAYLOAD && accept) pay_cnt <= pay_cnt + 1'b1;
            if (wr.en) wr_ptr <= wr_ptr + 1'b1;
            // one attempt per granted send
            if (state == IDLE && accept) attempt <= '0;
            else if (state == REQUEST && access_grant) attempt <= attempt + 1'b1;
            ack_cnt <= (state == ACK_WAIT) ? ack_cnt + 1'b1 : '0;
            if (state == ACK_WAIT && !ack_received && ack_timeout
                && attempt == 3'(`MAX_ATTEMPTS)) begin
                err_count <= err_count + 1'b1;
            end
        end
    end

    // read pointer, one-entry read stage and output register
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr     <= '0;
            rd_done    <= 1'b0;
            rd_pending <= 1'b0;
            rd_last    <= 1'b0;
            tx_valid   <= 1'b0;
            tx_last    <= 1'b0;
        end else begin
            if (rd_en) begin
                rd_ptr  <= rd_ptr + 1'b1;
                rd_last <= rd_ptr == frame_end;
                rd_done <= rd_ptr == frame_end;
            end else if (state != TRANSMIT) begin
                rd_ptr  <= '0;
                rd_done <= 1'b0;
            end
            if (rd_en) rd_pending <= 1'b1;
            else if (out_load) rd_pending <= 1'b0;
            if (out_load) begin
                tx_valid <= 1'b1;
                tx_last  <= rd_last;
            end else if (tx_ready) begin
                tx_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && accept) dest_q <= xdata;
        if (state == LOAD_FTYPE && accept) ftype_q <= xdata;
        if (wr.en) frame_end <= wr_ptr;
        if (out_load) tx_data <= rd_data;
    end

    tx_hold: assert property (
        @(posedge clk) disable iff (rst)
        tx_valid && !tx_ready |=> tx_valid && $stable(tx_data) && $stable(tx_last)
    ) else $error("tx byte changed while the modulator stalled");

endmodule

// ==== source/xmit_top.sv ====
module xmit_top (
    input  logic                   clk,
    input  logic                   rst,
    input  frame_pkg::byte_t       mac,
    input  logic                   xvalid,
    input  logic                   xsend,
    input  frame_pkg::byte_t       xdata,
    output logic                   xrdy,
    input  logic                   cardet,
    output logic                   tx_valid,
    input  logic                   tx_ready,
    output frame_pkg::byte_t       tx_data,
    output logic                   tx_last,
    input  logic                   ack_received,
    output link_pkg::xmit_status_t status
);
    import frame_pkg::*;

    field_sel_t field_sel;
    logic       strobe;
    logic       crc_clear;
    buf_wr_t    ctl_wr;
    buf_wr_t    buf_wr;
    byte_t      wr_byte;
    logic       rd_en;
    buf_addr_t  rd_addr;
    byte_t      rd_data;
    logic       access_req;
    logic       access_grant;

    // controller gives enable and address, assembler gives the stored byte
    assign buf_wr = '{en: ctl_wr.en, addr: ctl_wr.addr, data: wr_byte};

    xmit_controller u_ctl (
        .clk          (clk),
        .rst          (rst),
        .xvalid       (xvalid),
        .xsend        (xsend),
        .xdata        (xdata),
        .xrdy         (xrdy),
        .field_sel    (field_sel),
        .strobe       (strobe),
        .crc_clear    (crc_clear),
        .wr           (ctl_wr),
        .rd_en        (rd_en),
        .rd_addr      (rd_addr),
        .rd_data      (rd_data),
        .access_req   (access_req),
        .access_grant (access_grant),
        .tx_valid     (tx_valid),
        .tx_ready     (tx_ready),
        .tx_data      (tx_data),
        .tx_last      (tx_last),
        .ack_received (ack_received),
        .status       (status)
    );

    frame_assembler u_asm (
        .clk       (clk),
        .rst       (rst),
        .field_sel (field_sel),
        .host_byte (ctl_wr.data),
        .mac       (mac),
        .strobe    (strobe),
        .crc_clear (crc_clear),
        .wr_byte   (wr_byte)
    );

    frame_buffer u_buf (
        .clk     (clk),
        .rst     (rst),
        .wr      (buf_wr),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    backoff_timer u_bo (
        .clk          (clk),
        .rst          (rst),
        .cardet       (cardet),
        .access_req   (access_req),
        .access_grant (access_grant)
    );

endmodule

// ==== testbench/tb_xmit_top.sv ====
`include "xmit_config.svh"

module tb_xmit_top;
    import frame_pkg::*;
    import link_pkg::*;

    logic         clk;
    logic         rst;
    byte_t        mac;
    logic         xvalid;
    logic         xsend;
    byte_t        xdata;
    logic         xrdy;
    logic         cardet;
    logic         tx_valid;
    logic         tx_ready = 1'b1;
    byte_t        tx_data;
    logic         tx_last;
    logic         ack_received;
    xmit_status_t status;

    // expected stream as {last, data} per byte
    logic [8:0]   expected_q [$];
    byte_t        payload [$];
    logic [31:0]  lfsr_state = 32'h111;
    string        test_name;
    logic         gaps_on;
    int           errors;
    int           bytes_checked;
    int           frames_seen;
    int           quiet_cycles;
    int           frames_before;
    int           err_before;

    xmit_top DUT (
        .clk          (clk),
        .rst          (rst),
        .mac          (mac),
        .xvalid       (xvalid),
        .xsend        (xsend),
        .xdata        (xdata),
        .xrdy         (xrdy),
        .cardet       (cardet),
        .tx_valid     (tx_valid),
        .tx_ready     (tx_ready),
        .tx_data      (tx_data),
        .tx_last      (tx_last),
        .ack_received (ack_received),
        .status       (status)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // galois lfsr x^32+x^22+x^2+x+1 stepped once per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] val;
        logic        out;
        val = '0;
        for (int i = 0; i < n; i++) begin
            out = lfsr_state[0];
            lfsr_state = {1'b0, lfsr_state[31:1]} ^ (out ? 32'h8020_0003 : 32'h0);
            val = {val[30:0], out};
        end
        return val;
    endfunction

    // bit-serial crc-8 with poly 0x07 and zero start
    function automatic byte_t fcs_step(input byte_t crc, input byte_t data);
        byte_t c;
        logic  fb;
        c = crc;
        for (int i = 7; i >= 0; i--) begin
            fb = c[7] ^ data[i];
            c = {c[6:0], 1'b0} ^ (fb ? 8'h07 : 8'h00);
        end
        return c;
    endfunction

    task automatic report_timeout(input string what);
        errors++;
        $display("timeout waiting for %s in test %s", what, test_name);
    endtask

    task automatic check_value(input string what, input int expected, input int actual);
        value_ok: assert (expected == actual) else begin
            errors++;
            $display("[FAIL] %s %s: expected %0d, actual %0d", test_name, what, expected, actual);
        end
    endtask

    task automatic build_payload(input int n);
        payload.delete();
        for (int i = 0; i < n; i++) begin
            payload.push_back(8'(take_bits(8)));
        end
    endtask

    // model of the bytes on the modulator link for one send
    task automatic expect_frame(input byte_t dest, input ftype_t ftype);
        byte_t f [$];
        byte_t fcs;
        for (int i = 0; i < `PREAMBLE_LENGTH; i++) begin
            f.push_back(PREAMBLE_BYTE);
        end
        f.push_back(SFD_BYTE);
        f.push_back(dest);
        f.push_back(mac);
        f.push_back(ftype);
        foreach (payload[i]) begin
            f.push_back(payload[i]);
        end
        fcs = 8'h00;
        for (int i = `PREAMBLE_LENGTH + 1; i < f.size(); i++) begin
            fcs = fcs_step(fcs, f[i]);
        end
        if (ftype != FTYPE_RAW) begin
            f.push_back(fcs);
        end
        for (int i = 0; i < f.size(); i++) begin
            expected_q.push_back({i == f.size() - 1, f[i]});
        end
    endtask

    // hand the frame to the host port just after a rising edge
    task automatic load_frame(input byte_t dest, input ftype_t ftype);
        byte_t bytes [$];
        int    n;
        bytes.push_back(dest);
        bytes.push_back(ftype);
        foreach (payload[i]) begin
            bytes.push_back(payload[i]);
        end
        for (int i = 0; i < bytes.size(); i++) begin
            xvalid = 1'b1;
            xdata  = bytes[i];
            xsend  = i == bytes.size() - 1;
            n = 0;
            @(posedge clk);
            while (!xrdy && n < 100) begin
                @(posedge clk);
                n++;
            end
            if (!xrdy) begin
                report_timeout("host byte acceptance");
            end
            #1;
        end
        xvalid = 1'b0;
        xsend  = 1'b0;
    endtask

    task automatic wait_idle(input int limit);
        int n;
        n = 0;
        @(posedge clk);
        while (status.busy && n < limit) begin
            @(posedge clk);
            n++;
        end
        if (status.busy) begin
            report_timeout("transmitter idle");
        end
        #1;
        all_bytes_sent: assert (expected_q.size() == 0) else begin
            errors++;
            $display("%0d expected tx bytes never sent in %s", expected_q.size(), test_name);
            expected_q.delete();
        end
    endtask

    task automatic wait_frame_end(input int limit);
        int n;
        n = 0;
        @(posedge clk);
        while (!(tx_valid && tx_ready && tx_last) && n < limit) begin
            @(posedge clk);
            n++;
        end
        if (!(tx_valid && tx_ready && tx_last)) begin
            report_timeout("end of frame");
        end
        #1;
    endtask

    // modulator ready with random gaps when enabled
    always @(posedge clk) begin
        logic ready_next;
        ready_next = gaps_on ? (take_bits(2) != 0) : 1'b1;
        #1;
        tx_ready = ready_next;
    end

    always @(posedge clk) begin
        quiet_cycles <= (rst || cardet) ? 0 : quiet_cycles + 1;
    end

    always @(posedge clk) begin
        logic [8:0] want;
        if (!rst && tx_valid && tx_ready) begin
            no_extra_byte: assert (expected_q.size() > 0) else begin
                errors++;
                $display("unexpected tx byte %02h in %s", tx_data, test_name);
            end
            if (expected_q.size() > 0) begin
                want = expected_q.pop_front();
                bytes_checked++;
                tx_byte: assert ({tx_last, tx_data} == want) else begin
                    errors++;
                    $display("[FAIL] %s: expected %02h last %0b, actual %02h last %0b",
                             test_name, want[7:0], want[8], tx_data, tx_last);
                end
            end
            if (tx_last) begin
                frames_seen++;
            end
        end
    end

    stall_hold: assert property (@(posedge clk) disable iff (rst)
        tx_valid && !tx_ready |=> tx_valid && $stable(tx_data) && $stable(tx_last))
        else begin
            errors++;
            $display("tx byte changed or dropped during a stall in %s", test_name);
        end

    no_tx_on_carrier: assert property (@(posedge clk) disable iff (rst)
        cardet |-> !tx_valid)
        else begin
            errors++;
            $display("tx_valid high while the carrier was busy in %s", test_name);
        end

    defer_time: assert property (@(posedge clk) disable iff (rst)
        $rose(tx_valid) |-> quiet_cycles >= `DIFS_CYCLES + `SLOT_CYCLES)
        else begin
            errors++;
            $display("send started only %0d cycles after carrier went quiet in %s",
                     quiet_cycles, test_name);
        end

    initial begin
        rst          = 1'b1;
        mac          = 8'h3C;
        xvalid       = 1'b0;
        xsend        = 1'b0;
        xdata        = 8'h00;
        cardet       = 1'b0;
        ack_received = 1'b0;
        gaps_on      = 1'b0;
        errors       = 0;
        test_name    = "reset";
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        check_value("tx_valid", 0, int'(tx_valid));
        check_value("access_req", 0, int'(DUT.access_req));
        check_value("busy", 0, int'(status.busy));
        check_value("xrdy", 1, int'(xrdy));
        check_value("attempt", 0, int'(status.attempt));
        check_value("err_count", 0, int'(status.err_count));

        test_name = "data_frame";
        frames_before = frames_seen;
        build_payload(12);
        expect_frame(8'hA7, FTYPE_DATA);
        load_frame(8'hA7, FTYPE_DATA);
        wait_idle(1000);
        check_value("frames", 1, frames_seen - frames_before);

        test_name = "raw_frame";
        frames_before = frames_seen;
        build_payload(7);
        expect_frame(8'h19, FTYPE_RAW);
        load_frame(8'h19, FTYPE_RAW);
        wait_idle(1000);
        check_value("frames", 1, frames_seen - frames_before);

        test_name = "ready_gaps";
        gaps_on = 1'b1;
        build_payload(40);
        expect_frame(8'h6E, FTYPE_DATA);
        load_frame(8'h6E, FTYPE_DATA);
        wait_idle(2000);
        gaps_on = 1'b0;

        // carrier busy until well after the frame is stored
        test_name = "carrier_defer";
        cardet = 1'b1;
        build_payload(5);
        expect_frame(8'hC2, FTYPE_DATA);
        load_frame(8'hC2, FTYPE_DATA);
        repeat (40) @(posedge clk);
        #1;
        check_value("busy before carrier drop", 1, int'(status.busy));
        cardet = 1'b0;
        wait_idle(1000);

        test_name = "ack_first";
        frames_before = frames_seen;
        err_before = int'(status.err_count);
        build_payload(9);
        expect_frame(8'h44, FTYPE_ACKREQ);
        load_frame(8'h44, FTYPE_ACKREQ);
        wait_frame_end(1000);
        repeat (5) @(posedge clk);
        #1;
        ack_received = 1'b1;
        @(posedge clk);
        #1;
        ack_received = 1'b0;
        wait_idle(1000);
        check_value("frames", 1, frames_seen - frames_before);
        check_value("attempt", 1, int'(status.attempt));
        check_value("err_count", err_before, int'(status.err_count));

        // each retry must repeat the stored frame unchanged
        test_name = "no_ack";
        frames_before = frames_seen;
        err_before = int'(status.err_count);
        build_payload(6);
        for (int i = 0; i < `MAX_ATTEMPTS; i++) begin
            expect_frame(8'h8B, FTYPE_ACKREQ);
        end
        load_frame(8'h8B, FTYPE_ACKREQ);
        wait_idle(4000);
        check_value("frames", `MAX_ATTEMPTS, frames_seen - frames_before);
        check_value("attempt", `MAX_ATTEMPTS, int'(status.attempt));
        check_value("err_count", err_before + 1, int'(status.err_count));
        check_value("xrdy", 1, int'(xrdy));

        $display("checked %0d tx bytes in %0d frames, %0d errors",
                 bytes_checked, frames_seen, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
